// ==== common/mmio_uart_pkg.sv ====
package mmio_uart_pkg;

    // serial bit timing, kept short for simulation
    localparam int unsigned clks_per_bit = 8;
    localparam int unsigned bit_div_w = $clog2(clks_per_bit);

    // transmit buffer of 32-bit words, byte-addressed by the head pointer
    localparam int unsigned tx_buf_words = 64;
    localparam int unsigned tx_buf_aw = $clog2(tx_buf_words);
    localparam int unsigned tx_ptr_w = 8;

    // receive queue
    localparam int unsigned rx_queue_depth = 16;
    localparam int unsigned rx_ptr_w = $clog2(rx_queue_depth);
    localparam int unsigned rx_count_w = $clog2(rx_queue_depth + 1);

    // the region field sits above bit 8, because the tx register offsets use bit 8
    localparam int unsigned region_lsb = 9;
    localparam int unsigned region_w = 2;
    localparam logic [region_w-1:0] tx_region = 2'd0;
    localparam logic [region_w-1:0] rx_region = 2'd1;

    // full byte addresses of each region, for bus masters
    localparam logic [31:0] tx_base = 32'(tx_region) << region_lsb;
    localparam logic [31:0] rx_base = 32'(rx_region) << region_lsb;

    // register offsets inside a region
    localparam logic [region_lsb-1:0] tx_head_offset = 9'h100;
    localparam logic [region_lsb-1:0] tx_tail_offset = 9'h104;
    localparam logic [region_lsb-1:0] rx_data_offset = 9'h000;
    localparam logic [region_lsb-1:0] rx_status_offset = 9'h004;

    // rx status fields
    localparam int unsigned rx_status_ovf_bit = 8;

    typedef struct packed {
        logic        start;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mmio_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mmio_rsp_t;

endpackage

// ==== uart_tx/uart_tx_serializer.sv ====
`timescale 1ns/1ps

module uart_tx_serializer import mmio_uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       uart_tx
);

    typedef enum logic {
        st_idle,
        st_busy
    } ser_state_t;

    ser_state_t           state;
    logic [8:0]           shreg;
    logic [3:0]           bit_cnt;
    logic [bit_div_w-1:0] div_cnt;
    logic                 bit_end;

    assign tx_ready = (state == st_idle);
    assign bit_end = (div_cnt == bit_div_w'(clks_per_bit - 1));

    // control and line state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            uart_tx <= 1'b1;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (tx_start) begin
                        // start bit goes out right away
                        uart_tx <= 1'b0;
                        bit_cnt <= '0;
                        div_cnt <= '0;
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (bit_end) begin
                        div_cnt <= '0;
                        if (bit_cnt == 4'd9) begin
                            // stop bit done, line already high
                            state <= st_idle;
                        end else begin
                            uart_tx <= shreg[0];
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // data bits lsb first, then the stop bit from the top
    always_ff @(posedge clk) begin
        if (state == st_idle && tx_start) begin
            shreg <= {1'b1, tx_data};
        end else if (state == st_busy && bit_end) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

endmodule

// ==== uart_tx/mmio_uart_tx.sv ====
`timescale 1ns/1ps

module mmio_uart_tx import mmio_uart_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mmio_req_t req,
    output mmio_rsp_t rsp,
    output logic      uart_tx
);

    typedef enum logic {
        st_idle,
        st_wait_ready
    } drain_state_t;

    logic [31:0]           buffer [tx_buf_words];
    logic [tx_ptr_w-1:0]   head;
    logic [tx_ptr_w-1:0]   tail;
    logic [region_lsb-1:0] offset;
    logic [tx_buf_aw-1:0]  buf_idx;
    logic                  is_head;
    logic                  is_tail;
    logic                  is_buf;
    drain_state_t          state;
    logic [31:0]           word;
    logic                  tx_start;
    logic [7:0]            tx_data;
    logic                  tx_ready;

    assign offset = req.addr[region_lsb-1:0];
    assign buf_idx = req.addr[2 +: tx_buf_aw];
    assign is_head = (offset == tx_head_offset);
    assign is_tail = (offset == tx_tail_offset);
    assign is_buf = !is_head && !is_tail;

    // buffer writes from the bus
    always_ff @(posedge clk) begin
        if (req.start && req.write && is_buf) begin
            buffer[buf_idx] <= req.wdata;
        end
    end

    // read data registered one cycle after the command
    always_ff @(posedge clk) begin
        if (req.start && !req.write) begin
            if (is_head) begin
                rsp.rdata <= {{(32 - tx_ptr_w){1'b0}}, head};
            end else if (is_tail) begin
                rsp.rdata <= {{(32 - tx_ptr_w){1'b0}}, tail};
            end else begin
                rsp.rdata <= buffer[buf_idx];
            end
        end
    end

    // tail is software owned, head is not writable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail <= '0;
        end else if (req.start && req.write && is_tail) begin
            tail <= req.wdata[tx_ptr_w-1:0];
        end
    end

    // drain fsm, head wraps at 256
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            head <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (head != tail) begin
                        state <= st_wait_ready;
                    end
                end
                st_wait_ready: begin
                    // serializer busy means we just sit here
                    if (tx_ready) begin
                        tx_start <= 1'b1;
                        head <= head + 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // fetch the word under head, then pick the lane
    always_ff @(posedge clk) begin
        if (state == st_idle && head != tail) begin
            word <= buffer[head[tx_ptr_w-1:2]];
        end
        if (state == st_wait_ready && tx_ready) begin
            tx_data <= word[8*head[1:0] +: 8];
        end
    end

    uart_tx_serializer i_uart_tx_serializer (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .uart_tx  (uart_tx)
    );

endmodule

// ==== uart_rx/uart_rx_sampler.sv ====
`timescale 1ns/1ps

module uart_rx_sampler import mmio_uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } rx_state_t;

    rx_state_t            state;
    logic                 rx_meta;
    logic                 rx_sync;
    logic [2:0]           bit_cnt;
    logic [bit_div_w-1:0] div_cnt;
    logic                 half_bit;
    logic                 full_bit;

    assign half_bit = (div_cnt == bit_div_w'(clks_per_bit / 2 - 1));
    assign full_bit = (div_cnt == bit_div_w'(clks_per_bit - 1));

    // two-flop synchronizer, idles high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            bit_cnt <= '0;
            div_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            div_cnt <= div_cnt + 1'b1;
            case (state)
                st_idle: begin
                    div_cnt <= '0;
                    if (!rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // glitch check at the middle of the start bit
                    if (half_bit) begin
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state <= rx_sync ? st_idle : st_data;
                    end
                end
                st_data: begin
                    if (full_bit) begin
                        div_cnt <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_stop;
                        end
                    end
                end
                st_stop: begin
                    if (full_bit) begin
                        // bad stop bit drops the frame
                        rx_valid <= rx_sync;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == st_data && full_bit) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

endmodule

// ==== uart_rx/mmio_uart_rx.sv ====
`timescale 1ns/1ps

module mmio_uart_rx import mmio_uart_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mmio_req_t req,
    output mmio_rsp_t rsp,
    input  logic      uart_rx
);

    logic [7:0]            queue [rx_queue_depth];
    logic [rx_ptr_w-1:0]   wr_ptr;
    logic [rx_ptr_w-1:0]   rd_ptr;
    logic [rx_count_w-1:0] count;
    logic                  overflow;
    logic [region_lsb-1:0] offset;
    logic                  rd_cmd;
    logic                  full;
    logic                  pop;
    logic                  push;
    logic                  status_rd;
    logic                  rx_valid;
    logic [7:0]            rx_byte;

    assign offset = req.addr[region_lsb-1:0];
    assign rd_cmd = req.start && !req.write;
    assign full = (count == rx_count_w'(rx_queue_depth));
    assign pop = rd_cmd && (offset == rx_data_offset) && (count != '0);
    assign status_rd = rd_cmd && (offset == rx_status_offset);
    assign push = rx_valid && !full;

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= rx_byte;
        end
    end

    // pointers and count, push and pop may land together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + rx_count_w'(push) - rx_count_w'(pop);
        end
    end

    // sticky until status is read, a new overflow wins over the clear
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (rx_valid && full) begin
            overflow <= 1'b1;
        end else if (status_rd) begin
            overflow <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_cmd) begin
            rsp.rdata <= '0;
            if (pop) begin
                rsp.rdata[7:0] <= queue[rd_ptr];
            end else if (status_rd) begin
                rsp.rdata[rx_count_w-1:0] <= count;
                rsp.rdata[rx_status_ovf_bit] <= overflow;
            end
        end
    end

    uart_rx_sampler i_uart_rx_sampler (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

// ==== hdl/mmio_uart.sv ====
`timescale 1ns/1ps

module mmio_uart import mmio_uart_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  mmio_req_t req,
    output mmio_rsp_t rsp,
    output logic      cmd_ready,
    output logic      rdata_valid,
    output logic      uart_tx,
    input  logic      uart_rx
);

    logic [region_w-1:0] cmd_region;
    logic [region_w-1:0] last_region;
    mmio_req_t           tx_req;
    mmio_req_t           rx_req;
    mmio_rsp_t           tx_rsp;
    mmio_rsp_t           rx_rsp;

    // no stalls on this bus
    assign cmd_ready = 1'b1;
    assign rdata_valid = 1'b1;

    assign cmd_region = req.addr[region_lsb +: region_w];

    // each block only sees start for its own region
    always_comb begin
        tx_req = req;
        rx_req = req;
        tx_req.start = req.start && (cmd_region == tx_region);
        rx_req.start = req.start && (cmd_region == rx_region);
    end

    // remembers who answers the last command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_region <= tx_region;
        end else if (req.start) begin
            last_region <= cmd_region;
        end
    end

    assign rsp = (last_region == rx_region) ? rx_rsp : tx_rsp;

    mmio_uart_tx i_mmio_uart_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (tx_req),
        .rsp     (tx_rsp),
        .uart_tx (uart_tx)
    );

    mmio_uart_rx i_mmio_uart_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (rx_req),
        .rsp     (rx_rsp),
        .uart_rx (uart_rx)
    );

endmodule

// ==== test/tb_mmio_uart.sv ====
`timescale 1ns/1ps

module tb_mmio_uart import mmio_uart_pkg::*; ();

    typedef enum logic [2:0] {
        k_write,
        k_read,
        k_wait_count,
        k_wait_idle,
        k_frame,
        k_line_high
    } kind_t;

    typedef struct {
        kind_t       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic        loop;
        int          test_id;
    } entry_t;

    // one frame plus the drain gap between frames
    localparam int frame_cycles = 10 * int'(clks_per_bit) + 4;
    localparam int wait_limit = 20 * frame_cycles;
    localparam int idle_cycles = 11 * int'(clks_per_bit);

    localparam logic [31:0] head_addr = tx_base | 32'(tx_head_offset);
    localparam logic [31:0] tail_addr = tx_base | 32'(tx_tail_offset);
    localparam logic [31:0] data_addr = rx_base | 32'(rx_data_offset);
    localparam logic [31:0] status_addr = rx_base | 32'(rx_status_offset);

    logic      clk;
    logic      rst_n;
    mmio_req_t req;
    mmio_rsp_t rsp;
    logic      cmd_ready;
    logic      rdata_valid;
    logic      uart_tx;
    logic      loop_en;
    wire       serial_line;

    entry_t      stim_q [$];
    string       test_names [$];
    logic [7:0]  img [256];
    logic [7:0]  rx_model [$];
    logic        model_ovf;
    logic [7:0]  model_tail;
    logic        cur_loop;
    int          cur_test;
    integer      seed;
    int          checks;
    int          test_errors;
    int          errors;

    // loopback that idles high when broken
    assign serial_line = loop_en ? uart_tx : 1'b1;

    mmio_uart i_mmio_uart (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .rsp         (rsp),
        .cmd_ready   (cmd_ready),
        .rdata_valid (rdata_valid),
        .uart_tx     (uart_tx),
        .uart_rx     (serial_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic void add(kind_t kind, logic [31:0] addr, logic [31:0] data);
        entry_t e;
        e.kind = kind;
        e.addr = addr;
        e.data = data;
        e.loop = cur_loop;
        e.test_id = cur_test;
        stim_q.push_back(e);
    endfunction

    function automatic void begin_test(string name);
        test_names.push_back(name);
        cur_test = test_names.size() - 1;
    endfunction

    // expects the oldest byte or 0 from an empty queue
    function automatic void add_data_read();
        logic [31:0] exp;
        exp = '0;
        if (rx_model.size() > 0) begin
            exp[7:0] = rx_model.pop_front();
        end
        add(k_read, data_addr, exp);
    endfunction

    function automatic void add_status_read();
        logic [31:0] exp;
        exp = 32'(rx_model.size()) | (32'(model_ovf) << rx_status_ovf_bit);
        model_ovf = 1'b0;
        add(k_read, status_addr, exp);
    endfunction

    // packs random bytes behind the tail, rewrites touched words, then moves the tail
    function automatic logic [7:0] send_bytes(int n);
        logic [7:0] b;
        logic [7:0] first;
        logic [7:0] ptr;
        logic [7:0] base;
        logic [5:0] wi;
        bit         dirty [tx_buf_words];
        first = '0;
        ptr = model_tail;
        dirty = '{default: 1'b0};
        for (int i = 0; i < n; i++) begin
            b = 8'($random(seed));
            if (i == 0) begin
                first = b;
            end
            img[ptr] = b;
            dirty[ptr[7:2]] = 1'b1;
            if (rx_model.size() < int'(rx_queue_depth)) begin
                rx_model.push_back(b);
            end else begin
                model_ovf = 1'b1;
            end
            ptr = ptr + 8'd1;
        end
        for (int w = 0; w < int'(tx_buf_words); w++) begin
            wi = 6'(w);
            base = {wi, 2'b00};
            if (dirty[wi]) begin
                add(k_write, tx_base | 32'(base),
                    {img[base + 8'd3], img[base + 8'd2], img[base + 8'd1], img[base]});
            end
        end
        add(k_write, tail_addr, 32'(ptr));
        model_tail = ptr;
        return first;
    endfunction

    function automatic void build_table();
        logic [31:0] words [4];
        logic [31:0] offs [4];
        logic [7:0]  first;
        logic [7:0]  prev;
        offs = '{32'h00c, 32'h044, 32'h0a0, 32'h0fc};
        img = '{default: 8'h00};
        model_ovf = 1'b0;
        model_tail = '0;
        cur_loop = 1'b0;

        begin_test("reset_state");
        add(k_read, head_addr, 32'd0);
        add(k_read, tail_addr, 32'd0);
        add_status_read();
        add(k_line_high, 32'd0, 32'(4 * frame_cycles));

        begin_test("buffer_access");
        for (int i = 0; i < 4; i++) begin
            words[i] = 32'($random(seed));
            add(k_write, tx_base | offs[i], words[i]);
        end
        for (int i = 0; i < 4; i++) begin
            add(k_read, tx_base | offs[i], words[i]);
        end
        add(k_write, head_addr, 32'h0000_0055);
        add(k_read, head_addr, 32'd0);

        begin_test("loopback_order");
        cur_loop = 1'b1;
        first = send_bytes(6);
        add(k_frame, 32'd0, 32'(first));
        add(k_wait_count, 32'd0, 32'd6);
        repeat (6) add_data_read();
        add(k_read, head_addr, 32'(model_tail));
        add(k_read, tail_addr, 32'(model_tail));

        begin_test("queue_overflow");
        void'(send_bytes(20));
        add(k_wait_count, 32'd0, 32'(rx_queue_depth));
        add(k_wait_idle, 32'd0, 32'(model_tail));
        add_status_read();
        add_status_read();
        repeat (rx_queue_depth) add_data_read();
        add_data_read();
        add_status_read();

        begin_test("pointer_wrap");
        do begin
            prev = model_tail;
            void'(send_bytes(16));
            add(k_wait_count, 32'd0, 32'd16);
            repeat (16) add_data_read();
            add(k_read, head_addr, 32'(model_tail));
        end while (model_tail > prev);
        add(k_read, tail_addr, 32'(model_tail));
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    // driven at a falling edge so the command lands on the next rising edge
    task automatic bus_write(logic [31:0] addr, logic [31:0] data);
        req.start = 1'b1;
        req.write = 1'b1;
        req.addr = addr;
        req.wdata = data;
        check_value("cmd_ready", 32'd1, 32'(cmd_ready));
        @(negedge clk);
        req = '0;
    endtask

    task automatic bus_read(logic [31:0] addr, output logic [31:0] data);
        req.start = 1'b1;
        req.write = 1'b0;
        req.addr = addr;
        req.wdata = '0;
        check_value("cmd_ready", 32'd1, 32'(cmd_ready));
        @(negedge clk);
        req = '0;
        data = rsp.rdata;
        check_value("rdata_valid", 32'd1, 32'(rdata_valid));
    endtask

    task automatic wait_count(logic [31:0] exp);
        logic [31:0] st;
        int          cycles;
        bit          done;
        cycles = 0;
        done = 1'b0;
        while (!done && cycles < wait_limit) begin
            bus_read(status_addr, st);
            done = (32'(st[rx_count_w-1:0]) == exp);
            cycles++;
        end
        assert (done) else begin
            $display("timeout: rx count never reached %0d", exp);
            test_errors++;
        end
    endtask

    // head catches up with tail, then the line stays quiet for a frame
    task automatic wait_idle(logic [31:0] exp_tail);
        logic [31:0] hd;
        int          cycles;
        int          quiet;
        bit          head_ok;
        cycles = 0;
        quiet = 0;
        head_ok = 1'b0;
        while (!(head_ok && quiet >= idle_cycles) && cycles < wait_limit) begin
            if (!head_ok) begin
                bus_read(head_addr, hd);
                head_ok = (hd == exp_tail);
            end else begin
                @(negedge clk);
            end
            quiet = uart_tx ? quiet + 1 : 0;
            cycles++;
        end
        assert (head_ok && quiet >= idle_cycles) else begin
            $display("timeout: transmitter did not drain to tail %0d", exp_tail);
            test_errors++;
        end
    endtask

    task automatic check_frame(logic [7:0] exp);
        logic [9:0] bits;
        int         cycles;
        cycles = 0;
        bits = '0;
        while (uart_tx && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (!uart_tx) else begin
            $display("timeout: no start bit seen on uart_tx");
            test_errors++;
        end
        if (!uart_tx) begin
            repeat (clks_per_bit / 2) @(negedge clk);
            for (int i = 0; i < 10; i++) begin
                bits = {uart_tx, bits[9:1]};
                if (i < 9) begin
                    repeat (clks_per_bit) @(negedge clk);
                end
            end
            check_value("uart_tx start bit", 32'd0, 32'(bits[0]));
            check_value("uart_tx data bits", 32'(exp), 32'(bits[8:1]));
            check_value("uart_tx stop bit", 32'd1, 32'(bits[9]));
        end
    endtask

    task automatic check_line_high(logic [31:0] n);
        bit seen_low;
        seen_low = 1'b0;
        repeat (n) begin
            @(negedge clk);
            if (!uart_tx) begin
                seen_low = 1'b1;
            end
        end
        check_value("uart_tx idle level", 32'd1, seen_low ? 32'd0 : 32'd1);
    endtask

    task automatic finish_test(int id);
        if (test_errors == 0) begin
            $display("test %-16s ok", test_names[id]);
        end else begin
            $display("test %-16s %0d errors", test_names[id], test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        entry_t      e;
        logic [31:0] got;
        int          active;
        req = '0;
        rst_n = 1'b0;
        loop_en = 1'b0;
        seed = 32'hd8914507;
        checks = 0;
        test_errors = 0;
        errors = 0;
        active = 0;
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            if (e.test_id != active) begin
                finish_test(active);
                active = e.test_id;
            end
            loop_en = e.loop;
            case (e.kind)
                k_write: bus_write(e.addr, e.data);
                k_read: begin
                    bus_read(e.addr, got);
                    check_value($sformatf("rsp.rdata@%h", e.addr), e.data, got);
                end
                k_wait_count: wait_count(e.data);
                k_wait_idle: wait_idle(e.data);
                k_frame: check_frame(e.data[7:0]);
                k_line_high: check_line_high(e.data);
                default: begin
                    $display("unknown table entry at index %0d", i);
                    test_errors++;
                end
            endcase
        end
        finish_test(active);

        $display("tests %0d, checks %0d, errors %0d", test_names.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/mmio_uart_pkg.sv
uart_tx/uart_tx_serializer.sv
uart_tx/mmio_uart_tx.sv
uart_rx/uart_rx_sampler.sv
uart_rx/mmio_uart_rx.sv
hdl/mmio_uart.sv
test/tb_mmio_uart.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mmio_uart
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
